// ==== decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// raw instruction width
`define DEC_INST_W 32

// architectural register address
`define DEC_REG_ADDR_W 5

// immediate after sign extension
`define DEC_IMM_W 32

// instructions per accepted transfer
`define DEC_SLOTS 2

`endif

// ==== decode_pkg.sv ====
`include "decode_consts.svh"

package decode_pkg;

    // major opcode field, instruction bits 6..2
    typedef enum logic [4:0] {
        MAJ_LOAD      = 5'b00000,
        MAJ_MISC_MEM  = 5'b00011,
        MAJ_OP_IMM    = 5'b00100,
        MAJ_AUIPC     = 5'b00101,
        MAJ_OP_IMM_32 = 5'b00110,
        MAJ_STORE     = 5'b01000,
        MAJ_AMO       = 5'b01011,
        MAJ_OP        = 5'b01100,
        MAJ_LUI       = 5'b01101,
        MAJ_OP_32     = 5'b01110,
        MAJ_BRANCH    = 5'b11000,
        MAJ_JALR      = 5'b11001,
        MAJ_JAL       = 5'b11011,
        MAJ_SYSTEM    = 5'b11100
    } major_op_e;

    // back-end pipeline select
    typedef enum logic [3:0] {
        PIPE_XARITH = 4'd0,
        PIPE_XLOGIC = 4'd1,
        PIPE_XMUL   = 4'd2,
        PIPE_XDIV   = 4'd3
    } pipe_e;

    typedef enum logic [1:0] {
        XARITH_OP_ADD = 2'd0,
        XARITH_OP_SLT = 2'd1
    } xarith_op_e;

    typedef enum logic [2:0] {
        XLOGIC_OP_AND = 3'd0,
        XLOGIC_OP_OR  = 3'd1,
        XLOGIC_OP_XOR = 3'd2,
        XLOGIC_OP_SHF = 3'd3
    } xlogic_op_e;

    typedef struct packed {
        xarith_op_e opsel;
        logic       sub;
        logic       is_unsigned;
    } xarith_ctrl_t;

    typedef struct packed {
        logic [`DEC_REG_ADDR_W-1:0] rd;
        logic [`DEC_REG_ADDR_W-1:0] rs2;
        logic [`DEC_REG_ADDR_W-1:0] rs1;
    } reg_addr_t;

    typedef struct packed {
        logic                  legal;
        reg_addr_t             regs;
        logic [`DEC_IMM_W-1:0] imm;
        pipe_e                 pipe;
        xarith_ctrl_t          xarith;
        xlogic_op_e            xlogic_op;
    } decode_bundle_t;

endpackage

// ==== decode_stage.sv ====
`include "decode_consts.svh"

module decode_stage (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_input_valid,
    output logic                       o_input_ready,
    input  logic [`DEC_INST_W-1:0]     i_inst0,
    input  logic [`DEC_INST_W-1:0]     i_inst1,
    input  logic                       i_count,
    input  logic                       i_output_ready,
    output logic                       o_output_valid,
    output decode_pkg::decode_bundle_t o_bundle0,
    output decode_pkg::decode_bundle_t o_bundle1,
    output logic                       o_count
);
    // one registered entry, both slots plus the count bit
    typedef struct packed {
        decode_pkg::decode_bundle_t [`DEC_SLOTS-1:0] bundle;
        logic                                       count;
    } entry_t;

    logic [`DEC_SLOTS-1:0][`DEC_INST_W-1:0]      slot_inst;
    decode_pkg::decode_bundle_t [`DEC_SLOTS-1:0] slot_bundle;
    entry_t                                      entry_q;
    logic                                        entry_valid;
    logic                                        in_fire;
    logic                                        out_fire;

    assign slot_inst[0] = i_inst0;
    assign slot_inst[1] = i_inst1;

    for (genvar s = 0; s < `DEC_SLOTS; s++) begin : g_slot
        inst_decoder u_inst_decoder (
            .i_inst   (slot_inst[s]),
            .o_bundle (slot_bundle[s])
        );
    end

    // accept when empty or when the entry drains this cycle
    assign o_input_ready = !entry_valid || i_output_ready;
    assign in_fire       = i_input_valid && o_input_ready;
    assign out_fire      = entry_valid && i_output_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            entry_valid <= 1'b0;
        end else if (in_fire) begin
            entry_valid <= 1'b1;
        end else if (out_fire) begin
            entry_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (in_fire) begin
            entry_q.bundle <= slot_bundle;
            entry_q.count  <= i_count;
        end
    end

    assign o_output_valid = entry_valid;
    assign o_bundle0      = entry_q.bundle[0];
    assign o_bundle1      = entry_q.bundle[1];
    assign o_count        = entry_q.count;

    // a stalled entry must not move or change
    a_hold_under_backpressure: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_output_valid && !i_output_ready |=>
            $stable({o_output_valid, o_bundle0, o_bundle1, o_count})
    ) else $error("output changed while stalled");

    a_reset_empty: assert property (
        @(posedge i_clk) !i_rst_n |-> !o_output_valid
    ) else $error("output valid during reset");

endmodule

// ==== flist.f ====
+incdir+.
decode_pkg.sv
imm_decoder.sv
inst_decoder.sv
decode_stage.sv
tb_decode_stage.sv

// ==== imm_decoder.sv ====
`include "decode_consts.svh"

module imm_decoder (
    input  logic [`DEC_INST_W-1:0] i_inst,
    output logic [`DEC_IMM_W-1:0]  o_imm
);
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } imm_fmt_e;

    decode_pkg::major_op_e opcode;
    imm_fmt_e              fmt;
    logic                  sign;

    assign opcode = decode_pkg::major_op_e'(i_inst[6:2]);
    assign sign   = i_inst[31];

    // instruction format from the major opcode
    always_comb begin
        case (opcode)
            decode_pkg::MAJ_OP_IMM,
            decode_pkg::MAJ_OP_IMM_32,
            decode_pkg::MAJ_LOAD,
            decode_pkg::MAJ_MISC_MEM,
            decode_pkg::MAJ_JALR,
            decode_pkg::MAJ_SYSTEM:    fmt = FMT_I;
            decode_pkg::MAJ_STORE:     fmt = FMT_S;
            decode_pkg::MAJ_BRANCH:    fmt = FMT_B;
            decode_pkg::MAJ_LUI,
            decode_pkg::MAJ_AUIPC:     fmt = FMT_U;
            decode_pkg::MAJ_JAL:       fmt = FMT_J;
            default:                   fmt = FMT_R;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I: o_imm = {{(`DEC_IMM_W-12){sign}}, i_inst[31:20]};
            FMT_S: o_imm = {{(`DEC_IMM_W-12){sign}}, i_inst[31:25], i_inst[11:7]};
            // branch and jump offsets are halfword aligned
            FMT_B: o_imm = {{(`DEC_IMM_W-12){sign}}, i_inst[7], i_inst[30:25],
                            i_inst[11:8], 1'b0};
            FMT_U: o_imm = {{(`DEC_IMM_W-32){sign}}, i_inst[31:12], 12'b0};
            FMT_J: o_imm = {{(`DEC_IMM_W-20){sign}}, i_inst[19:12], i_inst[20],
                            i_inst[30:21], 1'b0};
            default: o_imm = '0;
        endcase
    end

endmodule

// ==== inst_decoder.sv ====
`include "decode_consts.svh"

module inst_decoder (
    input  logic [`DEC_INST_W-1:0]     i_inst,
    output decode_pkg::decode_bundle_t o_bundle
);
    decode_pkg::major_op_e      opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [`DEC_IMM_W-1:0]      imm;
    decode_pkg::decode_bundle_t dec;

    assign opcode = decode_pkg::major_op_e'(i_inst[6:2]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    imm_decoder u_imm_decoder (
        .i_inst (i_inst),
        .o_imm  (imm)
    );

    always_comb begin
        dec              = '0;
        dec.regs.rd      = i_inst[11:7];
        dec.regs.rs2     = i_inst[24:20];
        dec.regs.rs1     = i_inst[19:15];
        dec.imm          = imm;
        dec.pipe         = decode_pkg::PIPE_XARITH;
        dec.xarith.opsel = decode_pkg::XARITH_OP_ADD;
        dec.xlogic_op    = decode_pkg::XLOGIC_OP_AND;

        case (opcode)
            // addi slti sltiu xori ori andi slli srli srai
            decode_pkg::MAJ_OP_IMM: begin
                case (funct3)
                    3'b000: begin
                        dec.legal = 1'b1;
                    end
                    3'b001: begin
                        // rv64 shamt is six bits wide
                        dec.legal     = i_inst[31:26] == 6'b000000;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_SHF;
                    end
                    3'b010, 3'b011: begin
                        dec.legal        = 1'b1;
                        dec.xarith.opsel = decode_pkg::XARITH_OP_SLT;
                    end
                    3'b100: begin
                        dec.legal     = 1'b1;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_XOR;
                    end
                    3'b101: begin
                        dec.legal     = i_inst[31:26] == 6'b000000 ||
                                        i_inst[31:26] == 6'b010000;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_SHF;
                    end
                    3'b110: begin
                        dec.legal     = 1'b1;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_OR;
                    end
                    default: begin
                        dec.legal     = 1'b1;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_AND;
                    end
                endcase
                dec.xarith.is_unsigned = funct3[0];
            end

            // addiw slliw srliw sraiw
            decode_pkg::MAJ_OP_IMM_32: begin
                case (funct3)
                    3'b000: begin
                        dec.legal = 1'b1;
                    end
                    3'b001: begin
                        dec.legal     = funct7 == 7'b0000000;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_SHF;
                    end
                    3'b101: begin
                        dec.legal     = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_SHF;
                    end
                    default: begin
                        dec.legal = 1'b0;
                    end
                endcase
            end

            // add sub sll slt sltu xor srl sra or and
            decode_pkg::MAJ_OP: begin
                case (funct3)
                    3'b000: begin
                        dec.legal = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                    end
                    3'b001: begin
                        dec.legal     = funct7 == 7'b0000000;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_SHF;
                    end
                    3'b010, 3'b011: begin
                        dec.legal        = 1'b1;
                        dec.xarith.opsel = decode_pkg::XARITH_OP_SLT;
                    end
                    3'b100: begin
                        dec.legal     = 1'b1;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_XOR;
                    end
                    3'b101: begin
                        dec.legal     = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_SHF;
                    end
                    3'b110: begin
                        dec.legal     = 1'b1;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_OR;
                    end
                    default: begin
                        dec.legal     = 1'b1;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_AND;
                    end
                endcase
                dec.xarith.sub         = funct7[5];
                dec.xarith.is_unsigned = funct3[0];
            end

            // addw subw sllw srlw sraw
            decode_pkg::MAJ_OP_32: begin
                case (funct3)
                    3'b000: begin
                        dec.legal = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                    end
                    3'b001: begin
                        dec.legal     = funct7 == 7'b0000000;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_SHF;
                    end
                    3'b101: begin
                        dec.legal     = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                        dec.pipe      = decode_pkg::PIPE_XLOGIC;
                        dec.xlogic_op = decode_pkg::XLOGIC_OP_SHF;
                    end
                    default: begin
                        dec.legal = 1'b0;
                    end
                endcase
                dec.xarith.sub = funct7[5];
            end

            // lui and auipc are adds against zero or the pc
            decode_pkg::MAJ_LUI, decode_pkg::MAJ_AUIPC: begin
                dec.legal = 1'b1;
            end

            default: begin
                dec.legal = 1'b0;
            end
        endcase
    end

    assign o_bundle = dec;

    // only the integer pipes are reachable from this decoder
    always_comb begin
        a_legal_pipe: assert final (!o_bundle.legal ||
                                    o_bundle.pipe == decode_pkg::PIPE_XARITH ||
                                    o_bundle.pipe == decode_pkg::PIPE_XLOGIC)
            else $error("legal instruction routed to pipe %0d", o_bundle.pipe);
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -j 0 \
    --top-module tb_decode_stage \
    -Mdir "$BUILD_DIR" \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_decode_stage" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
else
    exit 1
fi

// ==== tb_decode_stage.sv ====
`include "decode_consts.svh"

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD       = 10;
    localparam int          RESET_CYCLES     = 10;
    localparam int          NUM_CASES        = 36;
    localparam int          NUM_ENTRIES      = NUM_CASES / `DEC_SLOTS;
    localparam int          CYCLES_PER_ENTRY = 40;
    localparam int          READY_PAT_LEN    = 256;
    localparam logic [31:0] SEED             = 32'h07bc913b;

    // per-slot compare fields
    localparam logic [5:0] F_LEGAL = 6'b000001;
    localparam logic [5:0] F_REGS  = 6'b000010;
    localparam logic [5:0] F_IMM   = 6'b000100;
    localparam logic [5:0] F_PIPE  = 6'b001000;
    localparam logic [5:0] F_ARITH = 6'b010000;
    localparam logic [5:0] F_LOGIC = 6'b100000;

    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;

    localparam decode_pkg::pipe_e      P_ARITH = decode_pkg::PIPE_XARITH;
    localparam decode_pkg::pipe_e      P_LOGIC = decode_pkg::PIPE_XLOGIC;
    localparam decode_pkg::xarith_op_e A_ADD   = decode_pkg::XARITH_OP_ADD;
    localparam decode_pkg::xarith_op_e A_SLT   = decode_pkg::XARITH_OP_SLT;
    localparam decode_pkg::xlogic_op_e L_AND   = decode_pkg::XLOGIC_OP_AND;
    localparam decode_pkg::xlogic_op_e L_OR    = decode_pkg::XLOGIC_OP_OR;
    localparam decode_pkg::xlogic_op_e L_XOR   = decode_pkg::XLOGIC_OP_XOR;
    localparam decode_pkg::xlogic_op_e L_SHF   = decode_pkg::XLOGIC_OP_SHF;

    typedef struct packed {
        logic [`DEC_SLOTS-1:0][`DEC_INST_W-1:0]      inst;
        decode_pkg::decode_bundle_t [`DEC_SLOTS-1:0] exp_b;
        logic [`DEC_SLOTS-1:0][5:0]                  mask;
        logic                                        count;
    } stim_entry_t;

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       i_input_valid;
    logic                       o_input_ready;
    logic [`DEC_INST_W-1:0]     i_inst0;
    logic [`DEC_INST_W-1:0]     i_inst1;
    logic                       i_count;
    logic                       i_output_ready;
    logic                       o_output_valid;
    decode_pkg::decode_bundle_t o_bundle0;
    decode_pkg::decode_bundle_t o_bundle1;
    logic                       o_count;

    stim_entry_t                stim_tab [NUM_ENTRIES];
    stim_entry_t                sb_q [$];
    int                         stamp_q [$];
    int                         gap_tab [NUM_ENTRIES];
    logic                       ready_pat [READY_PAT_LEN];
    int                         n_cases = 0;
    int                         in_idx = 0;
    int                         checked = 0;
    int                         cycle = 0;
    logic                       stream_mode = 1'b0;
    logic                       hold_pending = 1'b0;
    decode_pkg::decode_bundle_t held_b0;
    decode_pkg::decode_bundle_t held_b1;
    logic                       held_count;

    decode_stage DUT (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .o_input_ready  (o_input_ready),
        .i_inst0        (i_inst0),
        .i_inst1        (i_inst1),
        .i_count        (i_count),
        .i_output_ready (i_output_ready),
        .o_output_valid (o_output_valid),
        .o_bundle0      (o_bundle0),
        .o_bundle1      (o_bundle1),
        .o_count        (o_count)
    );

    initial begin : clock_gen
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic compare_bundle(input string port, input decode_pkg::decode_bundle_t act,
                                  input decode_pkg::decode_bundle_t want, input logic [5:0] m);
        if (m[0]) check_value({port, ".legal"}, 64'(act.legal), 64'(want.legal));
        if (m[1]) check_value({port, ".rd"}, 64'(act.regs.rd), 64'(want.regs.rd));
        if (m[1]) check_value({port, ".rs2"}, 64'(act.regs.rs2), 64'(want.regs.rs2));
        if (m[1]) check_value({port, ".rs1"}, 64'(act.regs.rs1), 64'(want.regs.rs1));
        if (m[2]) check_value({port, ".imm"}, 64'(act.imm), 64'(want.imm));
        if (m[3]) check_value({port, ".pipe"}, 64'(act.pipe), 64'(want.pipe));
        if (m[4]) check_value({port, ".xarith"}, 64'(act.xarith), 64'(want.xarith));
        if (m[5]) check_value({port, ".xlogic_op"}, 64'(act.xlogic_op), 64'(want.xlogic_op));
    endtask

    function automatic decode_pkg::decode_bundle_t make_bundle(
        input logic legal, input logic [4:0] rd, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [31:0] imm, input decode_pkg::pipe_e pipe,
        input decode_pkg::xarith_op_e opsel, input logic sub, input logic uns,
        input decode_pkg::xlogic_op_e xlop
    );
        decode_pkg::decode_bundle_t b;
        b                    = '0;
        b.legal              = legal;
        b.regs.rd            = rd;
        b.regs.rs2           = rs2;
        b.regs.rs1           = rs1;
        b.imm                = imm;
        b.pipe               = pipe;
        b.xarith.opsel       = opsel;
        b.xarith.sub         = sub;
        b.xarith.is_unsigned = uns;
        b.xlogic_op          = xlop;
        return b;
    endfunction

    // illegal rows compare legal alone and the class picks arith or logic controls
    function automatic logic [5:0] field_mask(input int legal, input decode_pkg::pipe_e pipe,
                                              input int has_imm);
        logic [5:0] m;
        if (legal == 0) return F_LEGAL;
        m = F_LEGAL | F_REGS | F_PIPE;
        if (has_imm != 0) m = m | F_IMM;
        if (pipe == P_ARITH) m = m | F_ARITH;
        else m = m | F_LOGIC;
        return m;
    endfunction

    task automatic add_case(input logic [31:0] inst, input decode_pkg::decode_bundle_t want,
                            input logic [5:0] m);
        int e;
        int s;
        e                    = n_cases / `DEC_SLOTS;
        s                    = n_cases % `DEC_SLOTS;
        stim_tab[e].inst[s]  = inst;
        stim_tab[e].exp_b[s] = want;
        stim_tab[e].mask[s]  = m;
        stim_tab[e].count    = e[0] ^ e[2];
        n_cases++;
    endtask

    // the i-type rs2 field overlaps imm[4:0]
    task automatic row_i(input logic [6:0] op, input logic [2:0] f3, input int rd,
                         input int rs1, input logic [11:0] imm12, input int legal,
                         input decode_pkg::pipe_e pipe, input decode_pkg::xarith_op_e opsel,
                         input int sub, input int uns, input decode_pkg::xlogic_op_e xlop);
        add_case({imm12, rs1[4:0], f3, rd[4:0], op},
                 make_bundle(legal[0], rd[4:0], imm12[4:0], rs1[4:0], {{20{imm12[11]}}, imm12},
                             pipe, opsel, sub[0], uns[0], xlop),
                 field_mask(legal, pipe, 1));
    endtask

    task automatic row_r(input logic [6:0] op, input logic [6:0] f7, input logic [2:0] f3,
                         input int rd, input int rs1, input int rs2, input int legal,
                         input decode_pkg::pipe_e pipe, input decode_pkg::xarith_op_e opsel,
                         input int sub, input int uns, input decode_pkg::xlogic_op_e xlop);
        add_case({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op},
                 make_bundle(legal[0], rd[4:0], rs2[4:0], rs1[4:0], 32'h0,
                             pipe, opsel, sub[0], uns[0], xlop),
                 field_mask(legal, pipe, 0));
    endtask

    task automatic row_u(input logic [6:0] op, input int rd, input logic [19:0] imm20);
        add_case({imm20, rd[4:0], op},
                 make_bundle(1'b1, rd[4:0], imm20[12:8], imm20[7:3], {imm20, 12'h000},
                             P_ARITH, A_ADD, 1'b0, 1'b0, L_AND),
                 field_mask(1, P_ARITH, 1));
    endtask

    task automatic row_illegal(input logic [31:0] inst, input logic [31:0] imm,
                               input int check_imm);
        add_case(inst, make_bundle(1'b0, 5'd0, 5'd0, 5'd0, imm, P_ARITH, A_ADD, 1'b0, 1'b0, L_AND),
                 (check_imm != 0) ? (F_LEGAL | F_IMM) : F_LEGAL);
    endtask

    function automatic logic [31:0] enc_s(input logic [11:0] imm12, input int rs2, input int rs1);
        return {imm12[11:5], rs2[4:0], rs1[4:0], 3'b010, imm12[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input int rs2, input int rs1);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic build_table();
        row_i(OPC_OP_IMM, 3'b000, 5, 6, 12'hffb, 1, P_ARITH, A_ADD, 0, 0, L_AND);
        row_i(OPC_OP_IMM, 3'b010, 7, 8, 12'h064, 1, P_ARITH, A_SLT, 0, 0, L_AND);
        row_i(OPC_OP_IMM, 3'b011, 9, 10, 12'hfff, 1, P_ARITH, A_SLT, 0, 1, L_AND);
        row_r(OPC_OP, 7'h00, 3'b000, 11, 12, 13, 1, P_ARITH, A_ADD, 0, 0, L_AND);
        row_r(OPC_OP, 7'h20, 3'b000, 14, 15, 16, 1, P_ARITH, A_ADD, 1, 0, L_AND);
        row_r(OPC_OP, 7'h00, 3'b010, 17, 18, 19, 1, P_ARITH, A_SLT, 0, 0, L_AND);
        row_r(OPC_OP, 7'h00, 3'b011, 20, 21, 22, 1, P_ARITH, A_SLT, 0, 1, L_AND);
        row_r(OPC_OP_32, 7'h00, 3'b000, 23, 24, 25, 1, P_ARITH, A_ADD, 0, 0, L_AND);
        row_r(OPC_OP_32, 7'h20, 3'b000, 26, 27, 28, 1, P_ARITH, A_ADD, 1, 0, L_AND);
        row_i(OPC_OP_IMM_32, 3'b000, 29, 30, 12'h7ff, 1, P_ARITH, A_ADD, 0, 0, L_AND);
        row_u(OPC_LUI, 1, 20'h80000);
        row_u(OPC_AUIPC, 2, 20'h12345);
        // logic class where srai carries funct7 in imm[11:5]
        row_i(OPC_OP_IMM, 3'b100, 3, 4, 12'hf00, 1, P_LOGIC, A_ADD, 0, 0, L_XOR);
        row_i(OPC_OP_IMM, 3'b110, 5, 6, 12'h555, 1, P_LOGIC, A_ADD, 0, 0, L_OR);
        row_i(OPC_OP_IMM, 3'b111, 7, 8, 12'h0f0, 1, P_LOGIC, A_ADD, 0, 0, L_AND);
        row_r(OPC_OP, 7'h00, 3'b100, 9, 10, 11, 1, P_LOGIC, A_ADD, 0, 0, L_XOR);
        row_r(OPC_OP, 7'h00, 3'b110, 12, 13, 14, 1, P_LOGIC, A_ADD, 0, 0, L_OR);
        row_r(OPC_OP, 7'h00, 3'b111, 15, 16, 17, 1, P_LOGIC, A_ADD, 0, 0, L_AND);
        row_i(OPC_OP_IMM, 3'b001, 18, 19, 12'h03f, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_i(OPC_OP_IMM, 3'b101, 20, 21, 12'h007, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_i(OPC_OP_IMM, 3'b101, 22, 23, 12'h421, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_r(OPC_OP, 7'h00, 3'b001, 24, 25, 26, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_r(OPC_OP, 7'h00, 3'b101, 27, 28, 29, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_r(OPC_OP, 7'h20, 3'b101, 30, 31, 1, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_r(OPC_OP_32, 7'h00, 3'b001, 2, 3, 4, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_r(OPC_OP_32, 7'h00, 3'b101, 5, 6, 7, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_r(OPC_OP_32, 7'h20, 3'b101, 8, 9, 10, 1, P_LOGIC, A_ADD, 0, 0, L_SHF);
        // illegal encodings
        row_r(OPC_OP, 7'h40, 3'b000, 1, 2, 3, 0, P_ARITH, A_ADD, 0, 0, L_AND);
        row_i(OPC_OP_IMM, 3'b001, 4, 5, 12'h805, 0, P_LOGIC, A_ADD, 0, 0, L_SHF);
        row_r(OPC_OP_32, 7'h00, 3'b010, 6, 7, 8, 0, P_ARITH, A_ADD, 0, 0, L_AND);
        row_i(OPC_LOAD, 3'b010, 1, 2, 12'h008, 0, P_ARITH, A_ADD, 0, 0, L_AND);
        row_illegal(enc_s(12'hff4, 5, 6), 32'hfffffff4, 1);
        row_illegal(enc_b(13'h1ff0, 2, 1), 32'hfffffff0, 1);
        row_illegal(enc_j(21'h000800, 1), 32'h00000800, 1);
        row_illegal(32'h00000073, 32'h0, 0);
        row_illegal(enc_j(21'h100000, 0), 32'hfff00000, 1);
    endtask

    // holds valid until a cycle where ready was seen high
    task automatic send_entry(input int e);
        logic accepted;
        i_input_valid = 1'b1;
        i_inst0       = stim_tab[e].inst[0];
        i_inst1       = stim_tab[e].inst[1];
        i_count       = stim_tab[e].count;
        accepted      = 1'b0;
        while (!accepted) begin
            @(negedge i_clk);
            accepted = o_input_ready;
            @(posedge i_clk);
            #1;
        end
        i_input_valid = 1'b0;
    endtask

    task automatic wait_drain(input int target);
        while (checked < target) @(negedge i_clk);
    endtask

    initial begin : sink
        i_output_ready = 1'b0;
        forever begin
            @(posedge i_clk);
            #1;
            if (stream_mode) i_output_ready = 1'b1;
            else i_output_ready = ready_pat[cycle % READY_PAT_LEN];
        end
    end

    // handshakes are sampled at the falling edge before the edge that takes them
    always @(negedge i_clk) begin : monitor
        stim_entry_t got;
        if (hold_pending) begin
            check_value("o_output_valid", 64'(o_output_valid), 64'd1);
            check_value("o_bundle0", 64'(o_bundle0), 64'(held_b0));
            check_value("o_bundle1", 64'(o_bundle1), 64'(held_b1));
            check_value("o_count", 64'(o_count), 64'(held_count));
            hold_pending = 1'b0;
        end
        if (stream_mode && i_input_valid) begin
            check_value("o_input_ready", 64'(o_input_ready), 64'd1);
        end
        if (o_output_valid && i_output_ready) begin
            if (sb_q.size() == 0) begin
                $display("output transfer at %0t with no accepted input pending", $time);
                $display("Simulation FAILED");
                $fatal(1, "scoreboard underflow");
            end
            got = sb_q.pop_front();
            compare_bundle("o_bundle0", o_bundle0, got.exp_b[0], got.mask[0]);
            compare_bundle("o_bundle1", o_bundle1, got.exp_b[1], got.mask[1]);
            check_value("o_count", 64'(o_count), 64'(got.count));
            if (stream_mode) begin
                check_value("latency cycle", 64'(cycle), 64'(stamp_q[0] + 1));
            end
            void'(stamp_q.pop_front());
            checked++;
        end
        if (o_output_valid && !i_output_ready) begin
            held_b0      = o_bundle0;
            held_b1      = o_bundle1;
            held_count   = o_count;
            hold_pending = 1'b1;
        end
        if (i_input_valid && o_input_ready) begin
            sb_q.push_back(stim_tab[in_idx % NUM_ENTRIES]);
            stamp_q.push_back(cycle);
            in_idx++;
        end
    end

    initial begin : watchdog
        #((RESET_CYCLES + 2 * NUM_ENTRIES * CYCLES_PER_ENTRY) * CLK_PERIOD);
        $display("timeout: outputs stopped draining, %0d of %0d entries checked",
                 checked, 2 * NUM_ENTRIES);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        i_rst_n       = 1'b0;
        i_input_valid = 1'b0;
        i_inst0       = '0;
        i_inst1       = '0;
        i_count       = 1'b0;
        void'($urandom(SEED));
        for (int e = 0; e < NUM_ENTRIES; e++) gap_tab[e] = $urandom_range(2, 0);
        for (int c = 0; c < READY_PAT_LEN; c++) ready_pat[c] = ($urandom_range(3, 0) != 0);
        build_table();

        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_value("o_output_valid", 64'(o_output_valid), 64'd0);
        check_value("o_input_ready", 64'(o_input_ready), 64'd1);

        // random input gaps against random back-pressure
        @(posedge i_clk);
        #1;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            repeat (gap_tab[e]) begin
                @(posedge i_clk);
                #1;
            end
            send_entry(e);
        end
        wait_drain(NUM_ENTRIES);

        // back to back with the sink always ready
        stream_mode = 1'b1;
        @(posedge i_clk);
        #1;
        for (int e = 0; e < NUM_ENTRIES; e++) send_entry(e);
        wait_drain(2 * NUM_ENTRIES);

        // the last pair leaves and nothing follows it
        repeat (2) @(negedge i_clk);
        check_value("o_output_valid", 64'(o_output_valid), 64'd0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
